//--- bench/rvvi_testdata.txt
# id vld order insn trap intr pc_r pc_w rd wdata | mst mie mca mscratch mepc acc op_en op addr
# | exp: vld x_wb x_wdata csr_wb mstatus mie mcause (record one cycle later), all hex
1 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
2 1 1 a00293 0 0 1000 1004 5 dead  0 0 0 0 0 0 0 0 0  1 20 dead 0 0 0 0
2 1 2 13 0 0 1004 1008 0 1234  0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0
2 1 3 b00313 0 0 1008 100c 6 beef  0 0 0 0 0 0 0 0 0  1 40 beef 0 0 0 0
2 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 1 4 30200073 1 0 100c 100 0 0  3f 3ffff 2b 0 0 0 0 0 0  1 0 0 23 221888 7fff0888 8000000b
3 1 5 13 0 1 100 104 0 0  5 12 3 0 0 0 0 0 0  1 0 0 23 200800 20080 3
3 1 6 13 0 0 104 108 0 0  5 12 3 0 0 0 0 0 0  1 0 0 0 200800 20080 3
4 0 0 0 0 0 0 0 0 0  5 12 3 cafe 0 1 1 1 340  0 0 0 0 0 0 0
4 1 7 13 0 0 108 10c 0 0  5 12 3 cafe 0 0 0 0 0  1 0 0 8 200800 20080 3
4 1 8 13 0 0 10c 110 0 0  5 12 3 cafe 0 0 0 0 0  1 0 0 0 200800 20080 3
4 0 0 0 0 0 0 0 0 0  5 12 3 cafe 0 1 1 2 340  0 0 0 0 0 0 0
4 1 9 13 0 0 110 114 0 0  5 12 3 cafe 0 0 0 0 0  1 0 0 8 200800 20080 3
4 0 0 0 0 0 0 0 0 0  5 12 3 cafe 0 1 1 3 340  0 0 0 0 0 0 0
4 1 a 13 0 0 114 118 0 0  5 12 3 cafe 0 0 0 0 0  1 0 0 8 200800 20080 3
4 0 0 0 0 0 0 0 0 0  5 12 3 cafe 0 1 1 0 340  0 0 0 0 0 0 0
4 1 b 13 0 0 118 11c 0 0  5 12 3 cafe 0 0 0 0 0  1 0 0 0 200800 20080 3
5 0 0 0 0 0 0 0 0 0  5 12 3 cafe 2000 0 0 0 0  0 0 0 0 0 0 0
5 1 c 13 0 0 11c 120 0 0  5 12 3 cafe 2000 0 0 0 0  1 0 0 10 200800 20080 3
5 1 d 13 0 0 120 124 0 0  5 12 3 cafe 2000 0 0 0 0  1 0 0 0 200800 20080 3
6 1 1234abcd9abc 7ffff 1 1 beef0 beef4 1f a5a5  5 12 3 cafe 2000 0 0 0 0  1 80000000 a5a5 0 200800 20080 3
6 0 0 0 0 0 0 0 0 0  5 12 3 cafe 2000 0 0 0 0  0 0 0 0 0 0 0

//--- rvvi_trace_bridge.f
common/rvvi_trace_pkg.sv
csr/csr_field_pack.sv
csr/csr_wb_track.sv
verilog/gpr_wb_decode.sv
verilog/retire_packer.sv
verilog/rvvi_trace_bridge.sv
bench/tb_rvvi_trace_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the trace bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rvvi_trace_bridge \
    -f rvvi_trace_bridge.f \
    -o sim_tb

# Log is judged below, not by the exit code
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- bench/tb_rvvi_trace_bridge.sv
// RVVI trace bridge testbench
module tb_rvvi_trace_bridge;

    ////////////////////
    // Vector columns
    localparam int NCOL     = 26;
    localparam int MAX_ROWS = 64;
    localparam int C_ID     = 0;
    localparam int C_VLD    = 1;
    localparam int C_ORD    = 2;
    localparam int C_INSN   = 3;
    localparam int C_TRAP   = 4;
    localparam int C_INTR   = 5;
    localparam int C_PCR    = 6;
    localparam int C_PCW    = 7;
    localparam int C_RD     = 8;
    localparam int C_WD     = 9;
    localparam int C_MST    = 10;
    localparam int C_MIE    = 11;
    localparam int C_MCA    = 12;
    localparam int C_MSCR   = 13;
    localparam int C_MEPC   = 14;
    localparam int C_ACC    = 15;
    localparam int C_OPN    = 16;
    localparam int C_OP     = 17;
    localparam int C_ADDR   = 18;
    localparam int C_EVLD   = 19;
    localparam int C_EXWB   = 20;
    localparam int C_EXWD   = 21;
    localparam int C_ECWB   = 22;
    localparam int C_EMST   = 23;
    localparam int C_EMIE   = 24;
    localparam int C_EMCA   = 25;

    // Fixed values on the write-decoded CSRs
    localparam logic [31:0] MTVEC_VAL = 32'h0000_0100;
    localparam logic [31:0] MTVAL_VAL = 32'h0000_abcd;

    logic        rvvi;
    logic        rst_n_i;
    logic        rvfi_valid_i;
    logic [63:0] rvfi_order_i;
    logic [31:0] rvfi_insn_i;
    logic        rvfi_trap_i;
    logic        rvfi_intr_i;
    logic [31:0] rvfi_pc_rdata_i;
    logic [31:0] rvfi_pc_wdata_i;
    logic [4:0]  rvfi_rd_addr_i;
    logic [31:0] rvfi_rd_wdata_i;
    logic [5:0]  mstatus_raw_i;
    logic [17:0] mie_raw_i;
    logic [5:0]  mcause_raw_i;
    logic [31:0] mtvec_i;
    logic [31:0] mscratch_i;
    logic [31:0] mepc_i;
    logic [31:0] mtval_i;
    logic        csr_access_i;
    logic        csr_op_en_i;
    logic [1:0]  csr_op_i;
    logic [11:0] csr_addr_i;

    logic              trace_valid_o;
    logic [63:0]       trace_order_o;
    logic [31:0]       trace_insn_o;
    logic              trace_trap_o;
    logic              trace_intr_o;
    logic [31:0]       trace_pc_rdata_o;
    logic [31:0]       trace_pc_wdata_o;
    logic [31:0]       trace_x_wb_o;
    logic [31:0]       trace_x_wdata_o;
    logic [6:0][31:0]  trace_csr_o;
    logic [6:0]        trace_csr_wb_o;

    // Vector store with one row per cycle
    logic [63:0] vec [0:MAX_ROWS-1][0:NCOL-1];
    int          nrows;
    int          total_chk;
    int          total_err;
    int          test_chk [0:15];
    int          test_err [0:15];
    int          last_id;
    int          ntests;

    rvvi_trace_bridge DUT (.*);

    ////////////////////
    // Clock
    initial begin
        rvvi = 1'b0;
        forever #20 rvvi = ~rvvi;
    end

    // Compare one field and log a mismatch
    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int id);
        total_chk++;
        test_chk[id]++;
        if (got !== exp) begin
            total_err++;
            test_err[id]++;
            $display("** Error at %0t: test %0d %s got %h expected %h",
                     $time, id, name, got, exp);
        end
    endtask

    // One line per finished test
    task automatic report_test(input int id);
        ntests++;
        if (test_err[id] == 0) begin
            $display("test %0d done: %0d checks, all ok", id, test_chk[id]);
        end else begin
            $display("test %0d done: %0d checks, %0d wrong", id, test_chk[id], test_err[id]);
        end
    endtask

    ////////////////////
    // Vector file
    // Split one vector line into the columns of the given row
    function automatic int parse_vector_line(input string line, input int row);
        int          cnt;
        logic [63:0] f [0:NCOL-1];
        cnt = $sscanf(line,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
            f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22],
            f[23], f[24], f[25]);
        if (cnt == NCOL) begin
            for (int c = 0; c < NCOL; c++) begin
                vec[row][c] = f[c];
            end
        end
        return cnt;
    endfunction

    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    guard;
        string line;
        nrows = 0;
        guard = 0;
        fd = $fopen("bench/rvvi_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file bench/rvvi_testdata.txt");
            total_err++;
        end else begin
            // Bounded read that skips comment and blank lines
            while (!$feof(fd) && guard < 500 && nrows < MAX_ROWS) begin
                guard++;
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 2 && line.getc(0) != "#") begin
                    cnt = parse_vector_line(line, nrows);
                    if (cnt != NCOL) begin
                        $display("malformed vector line, %0d fields read: %s", cnt, line);
                        total_err++;
                    end else begin
                        nrows++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // Stimulus
    task automatic drive_row(input int r);
        rvfi_valid_i    <= vec[r][C_VLD][0];
        rvfi_order_i    <= vec[r][C_ORD];
        rvfi_insn_i     <= vec[r][C_INSN][31:0];
        rvfi_trap_i     <= vec[r][C_TRAP][0];
        rvfi_intr_i     <= vec[r][C_INTR][0];
        rvfi_pc_rdata_i <= vec[r][C_PCR][31:0];
        rvfi_pc_wdata_i <= vec[r][C_PCW][31:0];
        rvfi_rd_addr_i  <= vec[r][C_RD][4:0];
        rvfi_rd_wdata_i <= vec[r][C_WD][31:0];
        mstatus_raw_i   <= vec[r][C_MST][5:0];
        mie_raw_i       <= vec[r][C_MIE][17:0];
        mcause_raw_i    <= vec[r][C_MCA][5:0];
        mscratch_i      <= vec[r][C_MSCR][31:0];
        mepc_i          <= vec[r][C_MEPC][31:0];
        csr_access_i    <= vec[r][C_ACC][0];
        csr_op_en_i     <= vec[r][C_OPN][0];
        csr_op_i        <= vec[r][C_OP][1:0];
        csr_addr_i      <= vec[r][C_ADDR][11:0];
    endtask

    // Quiet cycle that holds the CSR state
    task automatic drive_idle();
        rvfi_valid_i <= 1'b0;
        csr_access_i <= 1'b0;
        csr_op_en_i  <= 1'b0;
    endtask

    ////////////////////
    // Record check
    task automatic check_row(input int r);
        int id;
        id = int'(vec[r][C_ID]) & 15;
        if (id != last_id && last_id != 0) begin
            report_test(last_id);
        end
        last_id = id;
        check_field("trace_valid_o", trace_valid_o, vec[r][C_EVLD], id);
        check_field("trace_x_wb_o", trace_x_wb_o, vec[r][C_EXWB], id);
        check_field("trace_csr_wb_o", trace_csr_wb_o, vec[r][C_ECWB], id);
        // Payload only meaningful with a record
        if (vec[r][C_EVLD][0]) begin
            check_field("trace_order_o", trace_order_o, vec[r][C_ORD], id);
            check_field("trace_insn_o", trace_insn_o, vec[r][C_INSN], id);
            check_field("trace_trap_o", trace_trap_o, vec[r][C_TRAP], id);
            check_field("trace_intr_o", trace_intr_o, vec[r][C_INTR], id);
            check_field("trace_pc_rdata_o", trace_pc_rdata_o, vec[r][C_PCR], id);
            check_field("trace_pc_wdata_o", trace_pc_wdata_o, vec[r][C_PCW], id);
            check_field("trace_x_wdata_o", trace_x_wdata_o, vec[r][C_EXWD], id);
            check_field("mstatus", trace_csr_o[0], vec[r][C_EMST], id);
            check_field("mie", trace_csr_o[1], vec[r][C_EMIE], id);
            check_field("mtvec", trace_csr_o[2], MTVEC_VAL, id);
            check_field("mscratch", trace_csr_o[3], vec[r][C_MSCR], id);
            check_field("mepc", trace_csr_o[4], vec[r][C_MEPC], id);
            check_field("mcause", trace_csr_o[5], vec[r][C_EMCA], id);
            check_field("mtval", trace_csr_o[6], MTVAL_VAL, id);
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        int wait_cnt;
        rst_n_i         = 1'b0;
        rvfi_valid_i    = 1'b0;
        rvfi_order_i    = '0;
        rvfi_insn_i     = '0;
        rvfi_trap_i     = 1'b0;
        rvfi_intr_i     = 1'b0;
        rvfi_pc_rdata_i = '0;
        rvfi_pc_wdata_i = '0;
        rvfi_rd_addr_i  = '0;
        rvfi_rd_wdata_i = '0;
        mstatus_raw_i   = '0;
        mie_raw_i       = '0;
        mcause_raw_i    = '0;
        mtvec_i         = MTVEC_VAL;
        mscratch_i      = '0;
        mepc_i          = '0;
        mtval_i         = MTVAL_VAL;
        csr_access_i    = 1'b0;
        csr_op_en_i     = 1'b0;
        csr_op_i        = '0;
        csr_addr_i      = '0;
        total_chk       = 0;
        total_err       = 0;
        last_id         = 0;
        ntests          = 0;
        for (int t = 0; t < 16; t++) begin
            test_chk[t] = 0;
            test_err[t] = 0;
        end
        load_vectors();
        // Reset for two cycles
        @(posedge rvvi);
        @(negedge rvvi);
        // Record control outputs while reset is held
        check_field("trace_valid_o in reset", trace_valid_o, 64'd0, 1);
        check_field("trace_x_wb_o in reset", trace_x_wb_o, 64'd0, 1);
        check_field("trace_csr_wb_o in reset", trace_csr_wb_o, 64'd0, 1);
        @(posedge rvvi);
        rst_n_i <= 1'b1;
        // Row r is sampled one edge after it is driven
        for (int r = 0; r < nrows; r++) begin
            @(posedge rvvi);
            drive_row(r);
            @(negedge rvvi);
            if (r > 0) begin
                check_row(r - 1);
            end
        end
        @(posedge rvvi);
        drive_idle();
        @(negedge rvvi);
        if (nrows > 0) begin
            check_row(nrows - 1);
            report_test(last_id);
        end
        // Stream must fall idle
        wait_cnt = 0;
        while (trace_valid_o && wait_cnt < 20) begin
            @(negedge rvvi);
            wait_cnt++;
        end
        if (trace_valid_o) begin
            $display("trace_valid_o still high 20 cycles after the last retirement");
            total_err++;
        end
        $display("tests: %0d, checks: %0d, errors: %0d", ntests, total_chk, total_err);
        if (total_err == 0 && nrows > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/rvvi_trace_bridge.sv
// RVVI retirement trace bridge
module rvvi_trace_bridge (
    input  logic                                   rvvi,
    input  logic                                   rst_n_i,
    // Retirement port
    input  logic                                   rvfi_valid_i,
    input  logic [rvvi_trace_pkg::ORDER_W-1:0]     rvfi_order_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_insn_i,
    input  logic                                   rvfi_trap_i,
    input  logic                                   rvfi_intr_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_pc_rdata_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_pc_wdata_i,
    input  logic [rvvi_trace_pkg::GPR_ADDR_W-1:0]  rvfi_rd_addr_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_rd_wdata_i,
    // Raw CSR state
    input  logic [rvvi_trace_pkg::MSTATUS_RAW_W-1:0] mstatus_raw_i,
    input  logic [rvvi_trace_pkg::MIE_RAW_W-1:0]   mie_raw_i,
    input  logic [rvvi_trace_pkg::MCAUSE_RAW_W-1:0] mcause_raw_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        mtvec_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        mscratch_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        mepc_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        mtval_i,
    // CSR access strobes
    input  logic                                   csr_access_i,
    input  logic                                   csr_op_en_i,
    input  logic [$bits(rvvi_trace_pkg::csr_op_e)-1:0] csr_op_i,
    input  logic [rvvi_trace_pkg::CSR_ADDR_W-1:0]  csr_addr_i,
    // Trace record
    output logic                                   trace_valid_o,
    output logic [rvvi_trace_pkg::ORDER_W-1:0]     trace_order_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_insn_o,
    output logic                                   trace_trap_o,
    output logic                                   trace_intr_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_pc_rdata_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_pc_wdata_o,
    output logic [rvvi_trace_pkg::NUM_GPR-1:0]     trace_x_wb_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_x_wdata_o,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] trace_csr_o,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0] trace_csr_wb_o
);

    // Architectural CSR values, one slot per tracked CSR
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value;
    // Per-CSR update flags for the current retirement
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0] csr_wb_flags;
    // GPR writeback
    logic [rvvi_trace_pkg::NUM_GPR-1:0]     gpr_wb_mask;
    logic [rvvi_trace_pkg::XLEN-1:0]        gpr_wb_data;

    ////////////////////
    // CSR side
    csr_field_pack u_csr_field_pack (
        .mstatus_raw_i (mstatus_raw_i),
        .mie_raw_i     (mie_raw_i),
        .mcause_raw_i  (mcause_raw_i),
        .mtvec_i       (mtvec_i),
        .mscratch_i    (mscratch_i),
        .mepc_i        (mepc_i),
        .mtval_i       (mtval_i),
        .csr_value_o   (csr_value)
    );

    csr_wb_track u_csr_wb_track (
        .rvvi           (rvvi),
        .rst_n_i        (rst_n_i),
        .rvfi_valid_i   (rvfi_valid_i),
        .csr_access_i   (csr_access_i),
        .csr_op_en_i    (csr_op_en_i),
        .csr_op_i       (csr_op_i),
        .csr_addr_i     (csr_addr_i),
        .csr_value_i    (csr_value),
        .csr_wb_flags_o (csr_wb_flags)
    );

    ////////////////////
    // GPR side
    gpr_wb_decode u_gpr_wb_decode (
        .rvfi_rd_addr_i  (rvfi_rd_addr_i),
        .rvfi_rd_wdata_i (rvfi_rd_wdata_i),
        .gpr_wb_mask_o   (gpr_wb_mask),
        .gpr_wb_data_o   (gpr_wb_data)
    );

    // Record register, one cycle after retirement
    retire_packer u_retire_packer (
        .rvvi             (rvvi),
        .rst_n_i          (rst_n_i),
        .rvfi_valid_i     (rvfi_valid_i),
        .rvfi_order_i     (rvfi_order_i),
        .rvfi_insn_i      (rvfi_insn_i),
        .rvfi_trap_i      (rvfi_trap_i),
        .rvfi_intr_i      (rvfi_intr_i),
        .rvfi_pc_rdata_i  (rvfi_pc_rdata_i),
        .rvfi_pc_wdata_i  (rvfi_pc_wdata_i),
        .gpr_wb_mask_i    (gpr_wb_mask),
        .gpr_wb_data_i    (gpr_wb_data),
        .csr_value_i      (csr_value),
        .csr_wb_flags_i   (csr_wb_flags),
        .trace_valid_o    (trace_valid_o),
        .trace_order_o    (trace_order_o),
        .trace_insn_o     (trace_insn_o),
        .trace_trap_o     (trace_trap_o),
        .trace_intr_o     (trace_intr_o),
        .trace_pc_rdata_o (trace_pc_rdata_o),
        .trace_pc_wdata_o (trace_pc_wdata_o),
        .trace_x_wb_o     (trace_x_wb_o),
        .trace_x_wdata_o  (trace_x_wdata_o),
        .trace_csr_o      (trace_csr_o),
        .trace_csr_wb_o   (trace_csr_wb_o)
    );

endmodule

//--- verilog/retire_packer.sv
// Retirement trace record register
module retire_packer (
    input  logic                                   rvvi,
    input  logic                                   rst_n_i,
    input  logic                                   rvfi_valid_i,
    input  logic [rvvi_trace_pkg::ORDER_W-1:0]     rvfi_order_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_insn_i,
    input  logic                                   rvfi_trap_i,
    input  logic                                   rvfi_intr_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_pc_rdata_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        rvfi_pc_wdata_i,
    input  logic [rvvi_trace_pkg::NUM_GPR-1:0]     gpr_wb_mask_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]        gpr_wb_data_i,
    input  logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_i,
    input  logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0] csr_wb_flags_i,
    output logic                                   trace_valid_o,
    output logic [rvvi_trace_pkg::ORDER_W-1:0]     trace_order_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_insn_o,
    output logic                                   trace_trap_o,
    output logic                                   trace_intr_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_pc_rdata_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_pc_wdata_o,
    output logic [rvvi_trace_pkg::NUM_GPR-1:0]     trace_x_wb_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]        trace_x_wdata_o,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] trace_csr_o,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0] trace_csr_wb_o
);

    ////////////////////
    // Control part
    // valid and both masks live for one cycle per retirement
    always_ff @(posedge rvvi or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trace_valid_o  <= 1'b0;
            trace_x_wb_o   <= '0;
            trace_csr_wb_o <= '0;
        end else begin
            trace_valid_o  <= rvfi_valid_i;
            trace_x_wb_o   <= rvfi_valid_i ? gpr_wb_mask_i : '0;
            trace_csr_wb_o <= rvfi_valid_i ? csr_wb_flags_i : '0;
        end
    end

    ////////////////////
    // Payload part
    // Captured on retirement, held otherwise
    always_ff @(posedge rvvi) begin
        if (rvfi_valid_i) begin
            trace_order_o    <= rvfi_order_i;
            trace_insn_o     <= rvfi_insn_i;
            trace_trap_o     <= rvfi_trap_i;
            trace_intr_o     <= rvfi_intr_i;
            trace_pc_rdata_o <= rvfi_pc_rdata_i;
            trace_pc_wdata_o <= rvfi_pc_wdata_i;
            trace_x_wdata_o  <= gpr_wb_data_i;
            trace_csr_o      <= csr_value_i;
        end
    end

    // Back-to-back records only from back-to-back retirements
    a_valid_b2b : assert property (
        @(posedge rvvi) disable iff (!rst_n_i)
        (trace_valid_o && $past(trace_valid_o)) |->
            ($past(rvfi_valid_i) && $past(rvfi_valid_i, 2))
    ) else $error("trace_valid_o repeated without a retirement");

endmodule

//--- verilog/gpr_wb_decode.sv
// GPR writeback decoder
module gpr_wb_decode (
    input  logic [rvvi_trace_pkg::GPR_ADDR_W-1:0] rvfi_rd_addr_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]       rvfi_rd_wdata_i,
    output logic [rvvi_trace_pkg::NUM_GPR-1:0]    gpr_wb_mask_o,
    output logic [rvvi_trace_pkg::XLEN-1:0]       gpr_wb_data_o
);

    // Destination is a real register
    logic rd_valid;

    // x0 is hardwired, never written back
    assign rd_valid = (rvfi_rd_addr_i != '0);

    // One-hot select of the destination
    assign gpr_wb_mask_o = rd_valid ?
                           (rvvi_trace_pkg::NUM_GPR'(1) << rvfi_rd_addr_i) : '0;

    // Data only with a live mask bit
    assign gpr_wb_data_o = (|gpr_wb_mask_o) ? rvfi_rd_wdata_i : '0;

    // Mask shape check, skipped while the address is unknown
    always_comb begin
        if (!$isunknown(rvfi_rd_addr_i)) begin
            a_mask_onehot0 : assert ($onehot0(gpr_wb_mask_o) && !gpr_wb_mask_o[0])
                else $error("GPR writeback mask not one-hot or x0 set");
        end
    end

endmodule

//--- csr/csr_wb_track.sv
// CSR update flag tracker
module csr_wb_track (
    input  logic                                     rvvi,
    input  logic                                     rst_n_i,
    input  logic                                     rvfi_valid_i,
    input  logic                                     csr_access_i,
    input  logic                                     csr_op_en_i,
    input  logic [$bits(rvvi_trace_pkg::csr_op_e)-1:0] csr_op_i,
    input  logic [rvvi_trace_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
    input  logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_i,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0]   csr_wb_flags_o
);

    // Any modifying access this cycle
    logic                                    csr_wr;
    // Per-slot address match on a modifying access
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0]  wr_hit;
    // Per-slot value change against last cycle
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0]  value_chg;
    // Update event, source picked per slot
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0]  csr_event;
    // Updates seen since the last record
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0]  pending_q;
    logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] prev_value_q;

    ////////////////////
    // Event detection
    assign csr_wr = csr_access_i && csr_op_en_i &&
                    (csr_op_i != rvvi_trace_pkg::CSR_OP_READ);

    always_comb begin
        for (int i = 0; i < rvvi_trace_pkg::NUM_TRK_CSR; i++) begin
            wr_hit[i]    = csr_wr && (csr_addr_i == rvvi_trace_pkg::CSR_ADDR_TABLE[i]);
            value_chg[i] = (csr_value_i[i] != prev_value_q[i]);
        end
    end

    // Write decode for mtvec, mscratch, mtval
    // value compare for the others
    assign csr_event = (wr_hit & rvvi_trace_pkg::CSR_WR_DECODE_MASK) |
                       (value_chg & ~rvvi_trace_pkg::CSR_WR_DECODE_MASK);

    // Reported flags include this cycle's events
    assign csr_wb_flags_o = pending_q | csr_event;

    ////////////////////
    // State
    always_ff @(posedge rvvi or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_value_q <= '0;
        end else begin
            prev_value_q <= csr_value_i;
        end
    end

    always_ff @(posedge rvvi or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else if (rvfi_valid_i) begin
            // Flags handed to the record, start over
            pending_q <= '0;
        end else begin
            pending_q <= pending_q | csr_event;
        end
    end

    // Quiet retirement leaves nothing pending for the next record
    a_pending_clear_after_retire : assert property (
        @(posedge rvvi) disable iff (!rst_n_i)
        (rvfi_valid_i && (csr_event == '0)) |=> (pending_q == '0)
    ) else $error("pending CSR flags survived a retirement");

endmodule

//--- csr/csr_field_pack.sv
// CSR architectural value packer
module csr_field_pack (
    input  logic [rvvi_trace_pkg::MSTATUS_RAW_W-1:0] mstatus_raw_i,
    input  logic [rvvi_trace_pkg::MIE_RAW_W-1:0]     mie_raw_i,
    input  logic [rvvi_trace_pkg::MCAUSE_RAW_W-1:0]  mcause_raw_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]          mtvec_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]          mscratch_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]          mepc_i,
    input  logic [rvvi_trace_pkg::XLEN-1:0]          mtval_i,
    output logic [rvvi_trace_pkg::NUM_TRK_CSR-1:0][rvvi_trace_pkg::XLEN-1:0] csr_value_o
);

    logic [rvvi_trace_pkg::XLEN-1:0] mstatus_arch;
    logic [rvvi_trace_pkg::XLEN-1:0] mie_arch;
    logic [rvvi_trace_pkg::XLEN-1:0] mcause_arch;

    ////////////////////
    // mstatus
    always_comb begin
        // Unimplemented fields read zero
        mstatus_arch = '0;
        mstatus_arch[rvvi_trace_pkg::MSTATUS_TW_BIT]   = mstatus_raw_i[0];
        mstatus_arch[rvvi_trace_pkg::MSTATUS_MPRV_BIT] = mstatus_raw_i[1];
        // MPP is two bits
        mstatus_arch[rvvi_trace_pkg::MSTATUS_MPP_LSB +: 2] = mstatus_raw_i[3:2];
        mstatus_arch[rvvi_trace_pkg::MSTATUS_MPIE_BIT] = mstatus_raw_i[4];
        mstatus_arch[rvvi_trace_pkg::MSTATUS_MIE_BIT]  = mstatus_raw_i[5];
    end

    ////////////////////
    // mie
    always_comb begin
        mie_arch = '0;
        // Fast lines from raw bits 17:3
        mie_arch[rvvi_trace_pkg::MIE_FAST_LSB +: rvvi_trace_pkg::MIE_RAW_W-3] =
            mie_raw_i[rvvi_trace_pkg::MIE_RAW_W-1:3];
        mie_arch[rvvi_trace_pkg::MIE_EXT_BIT]   = mie_raw_i[2];
        mie_arch[rvvi_trace_pkg::MIE_TIMER_BIT] = mie_raw_i[1];
        mie_arch[rvvi_trace_pkg::MIE_SW_BIT]    = mie_raw_i[0];
    end

    ////////////////////
    // mcause
    always_comb begin
        mcause_arch = '0;
        // Interrupt flag sits in the top raw bit
        mcause_arch[rvvi_trace_pkg::MCAUSE_IRQ_BIT] =
            mcause_raw_i[rvvi_trace_pkg::MCAUSE_RAW_W-1];
        // Exception or interrupt code
        mcause_arch[rvvi_trace_pkg::MCAUSE_CODE_W-1:0] =
            mcause_raw_i[rvvi_trace_pkg::MCAUSE_CODE_W-1:0];
    end

    // Slot placement on the packed bus
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MSTATUS]  = mstatus_arch;
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MIE]      = mie_arch;
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MCAUSE]   = mcause_arch;
    // Full-width registers go straight through
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MTVEC]    = mtvec_i;
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MSCRATCH] = mscratch_i;
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MEPC]     = mepc_i;
    assign csr_value_o[rvvi_trace_pkg::CSR_IDX_MTVAL]    = mtval_i;

endmodule

//--- common/rvvi_trace_pkg.sv
// RVVI trace bridge shared definitions
package rvvi_trace_pkg;

    ////////////////////
    // Widths and counts
    localparam int XLEN        = 32;
    localparam int ORDER_W     = 64;
    localparam int NUM_GPR     = 32;
    localparam int GPR_ADDR_W  = 5;
    localparam int CSR_ADDR_W  = 12;
    localparam int NUM_TRK_CSR = 7;

    ////////////////////
    // Tracked CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS_ADDR  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE_ADDR      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC_ADDR    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH_ADDR = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC_ADDR     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE_ADDR   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL_ADDR    = 12'h343;

    // Slot of each CSR in the packed value bus and in the flag mask
    typedef enum logic [2:0] {
        CSR_IDX_MSTATUS  = 3'd0,
        CSR_IDX_MIE      = 3'd1,
        CSR_IDX_MTVEC    = 3'd2,
        CSR_IDX_MSCRATCH = 3'd3,
        CSR_IDX_MEPC     = 3'd4,
        CSR_IDX_MCAUSE   = 3'd5,
        CSR_IDX_MTVAL    = 3'd6
    } csr_idx_e;

    // Address per slot, slot 0 in the low word
    localparam logic [NUM_TRK_CSR-1:0][CSR_ADDR_W-1:0] CSR_ADDR_TABLE = {
        CSR_MTVAL_ADDR, CSR_MCAUSE_ADDR, CSR_MEPC_ADDR, CSR_MSCRATCH_ADDR,
        CSR_MTVEC_ADDR, CSR_MIE_ADDR, CSR_MSTATUS_ADDR
    };

    // Slots flagged by write decode, the rest by value change
    localparam logic [NUM_TRK_CSR-1:0] CSR_WR_DECODE_MASK =
        (NUM_TRK_CSR'(1) << CSR_IDX_MTVEC) |
        (NUM_TRK_CSR'(1) << CSR_IDX_MSCRATCH) |
        (NUM_TRK_CSR'(1) << CSR_IDX_MTVAL);

    // Core CSR operation codes
    typedef enum logic [1:0] {
        CSR_OP_READ  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    ////////////////////
    // Architectural field positions
    localparam int MSTATUS_TW_BIT   = 21;
    localparam int MSTATUS_MPRV_BIT = 17;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MIE_BIT  = 3;

    // 15 fast lines start at bit 16
    localparam int MIE_FAST_LSB  = 16;
    localparam int MIE_EXT_BIT   = 11;
    localparam int MIE_TIMER_BIT = 7;
    localparam int MIE_SW_BIT    = 3;

    localparam int MCAUSE_IRQ_BIT = 31;
    localparam int MCAUSE_CODE_W  = 5;

    // Raw field widths on the core side
    localparam int MSTATUS_RAW_W = 6;
    localparam int MIE_RAW_W     = 18;
    localparam int MCAUSE_RAW_W  = 6;

endpackage
